// File: all.f
smem_pkg.sv
smem_route_decode.sv
smem_bank_array.sv
smem_rsp_merge.sv
smem_unit.sv
tb_smem_unit.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_smem_unit \
    && ./obj_dir/Vtb_smem_unit | tee /dev/stderr | grep -q "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb_smem_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the shared-memory unit with a data-cache model,
// a shared-memory mirror and in-order response checking per lane
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_smem_unit;
    import smem_pkg::*;

    logic clk = 1'b0;
    logic rst_n = 1'b0;

    logic [1:0]                 core_req_valid = '0;
    mem_op_e [1:0]              core_req_op = {MEM_READ, MEM_READ};
    logic [1:0][ADDR_WIDTH-1:0] core_req_addr = '0;
    logic [1:0][WORD_SIZE-1:0]  core_req_byteen = '0;
    logic [1:0][DATA_WIDTH-1:0] core_req_data = '0;
    logic [1:0][TAG_WIDTH-1:0]  core_req_tag = '0;
    logic [1:0]                 core_req_ready;
    logic [1:0]                 core_rsp_valid;
    logic [1:0][DATA_WIDTH-1:0] core_rsp_data;
    logic [1:0][TAG_WIDTH-1:0]  core_rsp_tag;
    logic [1:0]                 core_rsp_ready = '0;
    logic [1:0]                 dcache_req_valid;
    mem_op_e [1:0]              dcache_req_op;
    logic [1:0][ADDR_WIDTH-1:0] dcache_req_addr;
    logic [1:0][WORD_SIZE-1:0]  dcache_req_byteen;
    logic [1:0][DATA_WIDTH-1:0] dcache_req_data;
    logic [1:0][TAG_WIDTH-1:0]  dcache_req_tag;
    logic [1:0]                 dcache_req_ready = '0;
    logic [1:0]                 dcache_rsp_valid = '0;
    logic [1:0][DATA_WIDTH-1:0] dcache_rsp_data = '0;
    logic [1:0][TAG_WIDTH-1:0]  dcache_rsp_tag = '0;
    logic [1:0]                 dcache_rsp_ready;

    int seed = 35;
    logic rsp_throttle = 1'b0;
    logic [TAG_WIDTH-1:0] next_tag = '0;

    // Reference models for data-cache words, the shared-memory mirror and expected responses
    logic [DATA_WIDTH-1:0] dc_mem [logic [ADDR_WIDTH-1:0]];
    logic [DATA_WIDTH-1:0] smem_ref [256];
    logic [DATA_WIDTH-1:0] dc_data_q [2][$];
    logic [TAG_WIDTH-1:0]  dc_tag_q [2][$];
    logic [1:0]            dc_wait [2];
    logic [DATA_WIDTH-1:0] exp_data [2][$];
    logic [TAG_WIDTH-1:0]  exp_tag [2][$];

    smem_unit #(
        .NUM_LANES (2)
    ) smem_unit_i (
        .clk (clk), .rst_n (rst_n),
        .core_req_valid (core_req_valid), .core_req_op (core_req_op),
        .core_req_addr (core_req_addr), .core_req_byteen (core_req_byteen),
        .core_req_data (core_req_data), .core_req_tag (core_req_tag),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid), .core_rsp_data (core_rsp_data),
        .core_rsp_tag (core_rsp_tag), .core_rsp_ready (core_rsp_ready),
        .dcache_req_valid (dcache_req_valid), .dcache_req_op (dcache_req_op),
        .dcache_req_addr (dcache_req_addr), .dcache_req_byteen (dcache_req_byteen),
        .dcache_req_data (dcache_req_data), .dcache_req_tag (dcache_req_tag),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid), .dcache_rsp_data (dcache_rsp_data),
        .dcache_rsp_tag (dcache_rsp_tag), .dcache_rsp_ready (dcache_rsp_ready)
    );

    always #20 clk = ~clk;

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string msg);
        $display("Timed out while %s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Untouched data-cache words read back a pattern of their full address
    function automatic logic [DATA_WIDTH-1:0] dc_read(input logic [ADDR_WIDTH-1:0] addr);
        if (dc_mem.exists(addr)) begin
            return dc_mem[addr];
        end
        return (addr * 32'h9E37_79B1) ^ 32'h1234_5678;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old,
            input logic [DATA_WIDTH-1:0] wdata, input logic [WORD_SIZE-1:0] be);
        logic [DATA_WIDTH-1:0] res;
        res = old;
        for (int b = 0; b < WORD_SIZE; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assert property (@(posedge clk) !rst_n || !$past(rst_n) |->
            core_rsp_valid == '0 && dcache_req_valid == '0)
        else report_error("valid output raised during or just after reset");

    for (genvar l = 0; l < 2; l++) begin : g_lane_checks
        assert property (@(posedge clk) disable iff (!rst_n)
                core_rsp_valid[l] && !core_rsp_ready[l] |=> core_rsp_valid[l]
                && $stable(core_rsp_data[l]) && $stable(core_rsp_tag[l]))
            else report_error("core response changed while stalled");
    end

    // Sample transfers at the rising edge and update the models
    always @(posedge clk) begin
        logic [7:0] word;
        logic [31:0] r;
        if (rst_n) begin
            for (int l = 0; l < 2; l++) begin
                word = core_req_addr[l][9:2];
                if (dcache_rsp_valid[l] && dcache_rsp_ready[l]) begin
                    void'(dc_data_q[l].pop_front());
                    void'(dc_tag_q[l].pop_front());
                    r = $random(seed);
                    dc_wait[l] = r[1:0];
                end else if (dc_wait[l] != 2'd0) begin
                    dc_wait[l] = dc_wait[l] - 2'd1;
                end
                if (dcache_req_valid[l]) begin
                    assert (dcache_req_addr[l][31:10] != 22'h10)
                        else report_error("window address sent to the data cache");
                    assert (dcache_req_op[l] == core_req_op[l]
                            && dcache_req_addr[l] == core_req_addr[l]
                            && dcache_req_byteen[l] == core_req_byteen[l]
                            && dcache_req_data[l] == core_req_data[l]
                            && dcache_req_tag[l] == core_req_tag[l])
                        else report_error("data-cache request payload differs");
                end
                if (dcache_req_valid[l] && dcache_req_ready[l]) begin
                    if (dcache_req_op[l] == MEM_WRITE) begin
                        dc_mem[dcache_req_addr[l]] = merge_bytes(dc_read(dcache_req_addr[l]),
                            dcache_req_data[l], dcache_req_byteen[l]);
                    end else begin
                        if (dc_data_q[l].size() == 0) begin
                            r = $random(seed);
                            dc_wait[l] = r[1:0];
                        end
                        dc_data_q[l].push_back(dc_read(dcache_req_addr[l]));
                        dc_tag_q[l].push_back(dcache_req_tag[l]);
                    end
                end
                if (core_rsp_valid[l] && core_rsp_ready[l]) begin
                    assert (exp_data[l].size() != 0)
                        else report_error("core response without an outstanding read");
                    assert (core_rsp_tag[l] == exp_tag[l][0]
                            && core_rsp_data[l] == exp_data[l][0])
                        else report_error("core response data or tag mismatch");
                    void'(exp_data[l].pop_front());
                    void'(exp_tag[l].pop_front());
                end
                if (core_req_valid[l] && core_req_ready[l]) begin
                    if (core_req_addr[l][31:10] == 22'h10) begin
                        if (core_req_op[l] == MEM_WRITE) begin
                            smem_ref[word] = merge_bytes(smem_ref[word], core_req_data[l],
                                core_req_byteen[l]);
                        end else begin
                            exp_data[l].push_back(smem_ref[word]);
                            exp_tag[l].push_back(core_req_tag[l]);
                        end
                    end else begin
                        assert (dcache_req_valid[l] && dcache_req_ready[l])
                            else report_error("request outside the window missed the data cache");
                        if (core_req_op[l] == MEM_READ) begin
                            exp_data[l].push_back(dc_read(core_req_addr[l]));
                            exp_tag[l].push_back(core_req_tag[l]);
                        end
                    end
                end
            end
        end
    end

    // Data-cache handshakes and core back-pressure change on the falling edge
    always @(negedge clk) begin
        logic [31:0] r;
        for (int l = 0; l < 2; l++) begin
            r = $random(seed);
            dcache_req_ready[l] = r[0];
            core_rsp_ready[l] = rsp_throttle ? r[1] : 1'b1;
            dcache_rsp_valid[l] = (dc_data_q[l].size() != 0) && (dc_wait[l] == 2'd0);
            if (dc_data_q[l].size() != 0) begin
                dcache_rsp_data[l] = dc_data_q[l][0];
                dcache_rsp_tag[l] = dc_tag_q[l][0];
            end
        end
    end

    task automatic load_lane(input int l, input mem_op_e op, input logic [31:0] addr,
            input logic [3:0] be, input logic [31:0] data);
        core_req_op[l] = op;
        core_req_addr[l] = addr;
        core_req_byteen[l] = be;
        core_req_data[l] = data;
        core_req_tag[l] = next_tag;
        next_tag = next_tag + 8'd1;
    endtask

    // Starts and returns on a falling edge once every lane in mask has moved
    task automatic launch(input logic [1:0] mask);
        logic [1:0] done;
        int cycles;
        cycles = 0;
        core_req_valid = mask;
        while (core_req_valid != 2'b00) begin
            @(posedge clk);
            done = core_req_valid & core_req_ready;
            @(negedge clk);
            core_req_valid = core_req_valid & ~done;
            cycles++;
            if (cycles > 200) timeout_fail("waiting for a core request to be accepted");
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_data[0].size() != 0 || exp_data[1].size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 500) timeout_fail("waiting for outstanding reads to return");
        end
    endtask

    task automatic random_request(input int l);
        logic [31:0] r;
        logic [31:0] d;
        r = $random(seed);
        d = $random(seed);
        case (r[1:0])
            2'd0: load_lane(l, MEM_READ, {20'd0, r[13:4], 2'b00}, 4'hf, d);
            2'd1: load_lane(l, MEM_WRITE, {20'd0, r[13:4], 2'b00}, r[19:16], d);
            2'd2: load_lane(l, MEM_READ, 32'h4000 + {26'd0, r[7:4], 2'b00}, 4'hf, d);
            default: load_lane(l, MEM_WRITE, 32'h4000 + {26'd0, r[7:4], 2'b00}, r[19:16], d);
        endcase
    endtask

    initial begin
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] r;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // Fill the first sixteen shared-memory words with full-word writes
        for (int w = 0; w < 16; w += 2) begin
            d0 = $random(seed);
            d1 = $random(seed);
            load_lane(0, MEM_WRITE, 32'h4000 + w * 4, 4'hf, d0);
            load_lane(1, MEM_WRITE, 32'h4000 + (w + 1) * 4, 4'hf, d1);
            launch(2'b11);
        end

        // Partial writes followed by read-back of the same words
        for (int w = 0; w < 16; w++) begin
            r = $random(seed);
            load_lane(w % 2, MEM_WRITE, 32'h4000 + w * 4, r[3:0], $random(seed));
            launch(w % 2 == 0 ? 2'b01 : 2'b10);
            load_lane(w % 2, MEM_READ, 32'h4000 + w * 4, 4'hf, 32'd0);
            launch(w % 2 == 0 ? 2'b01 : 2'b10);
        end
        drain();

        // Mixed traffic on both lanes with a throttled core response port
        rsp_throttle = 1'b1;
        for (int n = 0; n < 60; n++) begin
            random_request(0);
            random_request(1);
            launch(2'b11);
        end
        drain();
        rsp_throttle = 1'b0;
        repeat (2) @(negedge clk);

        // Both lanes read bank 0 in the same cycle and lane 0 has priority
        load_lane(0, MEM_READ, 32'h4000, 4'hf, 32'd0);
        load_lane(1, MEM_READ, 32'h4008, 4'hf, 32'd0);
        core_req_valid = 2'b11;
        @(posedge clk);
        assert (core_req_ready == 2'b01)
            else report_error("same-bank arbitration did not favor lane 0");
        @(negedge clk);
        core_req_valid = 2'b10;
        launch(2'b10);
        drain();

        repeat (4) @(negedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// File: smem_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared-memory unit of one core: decode, banked memory and response merge
// between the core load/store lanes and the data-cache port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module smem_unit #(
    parameter int NUM_LANES     = 2,
    parameter int NUM_BANKS     = 2,
    parameter int SMEM_LOG_SIZE = 10,
    parameter logic [smem_pkg::ADDR_WIDTH-1:0] SMEM_BASE = 32'h0000_4000
) (
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [NUM_LANES-1:0]                            core_req_valid,
    input  smem_pkg::mem_op_e [NUM_LANES-1:0]               core_req_op,
    input  logic [NUM_LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]  core_req_addr,
    input  logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   core_req_byteen,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  core_req_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   core_req_tag,
    output logic [NUM_LANES-1:0]                            core_req_ready,

    output logic [NUM_LANES-1:0]                            core_rsp_valid,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  core_rsp_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   core_rsp_tag,
    input  logic [NUM_LANES-1:0]                            core_rsp_ready,

    output logic [NUM_LANES-1:0]                            dcache_req_valid,
    output smem_pkg::mem_op_e [NUM_LANES-1:0]               dcache_req_op,
    output logic [NUM_LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]  dcache_req_addr,
    output logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   dcache_req_byteen,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  dcache_req_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   dcache_req_tag,
    input  logic [NUM_LANES-1:0]                            dcache_req_ready,

    input  logic [NUM_LANES-1:0]                            dcache_rsp_valid,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  dcache_rsp_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   dcache_rsp_tag,
    output logic [NUM_LANES-1:0]                            dcache_rsp_ready
);
    import smem_pkg::*;

    localparam int SMEM_AW = SMEM_LOG_SIZE - $clog2(WORD_SIZE);

    // Decode to bank array
    logic [NUM_LANES-1:0]                 smem_req_valid;
    mem_op_e [NUM_LANES-1:0]              smem_req_op;
    logic [NUM_LANES-1:0][SMEM_AW-1:0]    smem_req_addr;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0]  smem_req_byteen;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] smem_req_data;
    logic [NUM_LANES-1:0][TAG_WIDTH-1:0]  smem_req_tag;
    logic [NUM_LANES-1:0]                 smem_req_ready;

    // Bank array to merge
    logic [NUM_LANES-1:0]                 smem_rsp_valid;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] smem_rsp_data;
    logic [NUM_LANES-1:0][TAG_WIDTH-1:0]  smem_rsp_tag;
    logic [NUM_LANES-1:0]                 smem_rsp_ready;

    // Read order bookkeeping between decode and merge
    logic [NUM_LANES-1:0]                 order_push;
    route_e [NUM_LANES-1:0]               order_route;
    logic [NUM_LANES-1:0]                 order_full;

    smem_route_decode #(
        .NUM_LANES     (NUM_LANES),
        .SMEM_LOG_SIZE (SMEM_LOG_SIZE),
        .NUM_BANKS     (NUM_BANKS),
        .SMEM_BASE     (SMEM_BASE)
    ) decode_i (
        .core_req_valid    (core_req_valid),
        .core_req_op       (core_req_op),
        .core_req_addr     (core_req_addr),
        .core_req_byteen   (core_req_byteen),
        .core_req_data     (core_req_data),
        .core_req_tag      (core_req_tag),
        .core_req_ready    (core_req_ready),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_op     (dcache_req_op),
        .dcache_req_addr   (dcache_req_addr),
        .dcache_req_byteen (dcache_req_byteen),
        .dcache_req_data   (dcache_req_data),
        .dcache_req_tag    (dcache_req_tag),
        .dcache_req_ready  (dcache_req_ready),
        .smem_req_valid    (smem_req_valid),
        .smem_req_op       (smem_req_op),
        .smem_req_addr     (smem_req_addr),
        .smem_req_byteen   (smem_req_byteen),
        .smem_req_data     (smem_req_data),
        .smem_req_tag      (smem_req_tag),
        .smem_req_ready    (smem_req_ready),
        .order_push        (order_push),
        .order_route       (order_route),
        .order_full        (order_full)
    );

    smem_bank_array #(
        .NUM_LANES     (NUM_LANES),
        .SMEM_LOG_SIZE (SMEM_LOG_SIZE),
        .NUM_BANKS     (NUM_BANKS)
    ) bank_array_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .smem_req_valid  (smem_req_valid),
        .smem_req_op     (smem_req_op),
        .smem_req_addr   (smem_req_addr),
        .smem_req_byteen (smem_req_byteen),
        .smem_req_data   (smem_req_data),
        .smem_req_tag    (smem_req_tag),
        .smem_req_ready  (smem_req_ready),
        .smem_rsp_valid  (smem_rsp_valid),
        .smem_rsp_data   (smem_rsp_data),
        .smem_rsp_tag    (smem_rsp_tag),
        .smem_rsp_ready  (smem_rsp_ready)
    );

    smem_rsp_merge #(
        .NUM_LANES (NUM_LANES)
    ) rsp_merge_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .order_push       (order_push),
        .order_route      (order_route),
        .order_full       (order_full),
        .smem_rsp_valid   (smem_rsp_valid),
        .smem_rsp_data    (smem_rsp_data),
        .smem_rsp_tag     (smem_rsp_tag),
        .smem_rsp_ready   (smem_rsp_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_data  (dcache_rsp_data),
        .dcache_rsp_tag   (dcache_rsp_tag),
        .dcache_rsp_ready (dcache_rsp_ready),
        .core_rsp_valid   (core_rsp_valid),
        .core_rsp_data    (core_rsp_data),
        .core_rsp_tag     (core_rsp_tag),
        .core_rsp_ready   (core_rsp_ready)
    );

endmodule

// File: smem_rsp_merge.sv
// ~~~~~~~~~~~~~~~~~~~~
// Result stage: returns shared-memory and data-cache read data to each lane
// in the order the reads were accepted
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module smem_rsp_merge #(
    parameter int NUM_LANES = 2
) (
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [NUM_LANES-1:0]                            order_push,
    input  smem_pkg::route_e [NUM_LANES-1:0]                order_route,
    output logic [NUM_LANES-1:0]                            order_full,

    input  logic [NUM_LANES-1:0]                            smem_rsp_valid,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  smem_rsp_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   smem_rsp_tag,
    output logic [NUM_LANES-1:0]                            smem_rsp_ready,

    input  logic [NUM_LANES-1:0]                            dcache_rsp_valid,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  dcache_rsp_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   dcache_rsp_tag,
    output logic [NUM_LANES-1:0]                            dcache_rsp_ready,

    output logic [NUM_LANES-1:0]                            core_rsp_valid,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  core_rsp_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   core_rsp_tag,
    input  logic [NUM_LANES-1:0]                            core_rsp_ready
);
    import smem_pkg::*;

    localparam int PTR_W = $clog2(ORDER_DEPTH);
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    route_e queue_q [NUM_LANES][ORDER_DEPTH];

    logic [NUM_LANES-1:0][PTR_W-1:0] wr_ptr_q;
    logic [NUM_LANES-1:0][PTR_W-1:0] rd_ptr_q;
    logic [NUM_LANES-1:0][CNT_W-1:0] count_q;
    logic [NUM_LANES-1:0]            head_smem;
    logic [NUM_LANES-1:0]            not_empty;
    logic [NUM_LANES-1:0]            pop;

    // The head route alone decides which source reaches the core
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            not_empty[i] = (count_q[i] != '0);
            head_smem[i] = (queue_q[i][rd_ptr_q[i]] == ROUTE_SMEM);
            order_full[i] = (count_q[i] == CNT_W'(ORDER_DEPTH));

            core_rsp_valid[i] = not_empty[i]
                                && (head_smem[i] ? smem_rsp_valid[i] : dcache_rsp_valid[i]);
            core_rsp_data[i]  = head_smem[i] ? smem_rsp_data[i] : dcache_rsp_data[i];
            core_rsp_tag[i]   = head_smem[i] ? smem_rsp_tag[i] : dcache_rsp_tag[i];

            smem_rsp_ready[i]   = not_empty[i] && head_smem[i] && core_rsp_ready[i];
            dcache_rsp_ready[i] = not_empty[i] && !head_smem[i] && core_rsp_ready[i];
            pop[i] = core_rsp_valid[i] && core_rsp_ready[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (order_push[i]) begin
                queue_q[i][wr_ptr_q[i]] <= order_route[i];
            end
        end
    end

    // Pointers wrap on their own since ORDER_DEPTH is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (order_push[i]) begin
                    wr_ptr_q[i] <= wr_ptr_q[i] + 1'b1;
                end
                if (pop[i]) begin
                    rd_ptr_q[i] <= rd_ptr_q[i] + 1'b1;
                end
                if (order_push[i] && !pop[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end else if (pop[i] && !order_push[i]) begin
                    count_q[i] <= count_q[i] - 1'b1;
                end
            end
        end
    end

endmodule

// File: smem_bank_array.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage: banked on-chip shared memory with per-bank lane arbitration
// and one registered read response per lane
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module smem_bank_array #(
    parameter int NUM_LANES     = 2,
    parameter int SMEM_LOG_SIZE = 10,
    parameter int NUM_BANKS     = 2
) (
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [NUM_LANES-1:0]                            smem_req_valid,
    input  smem_pkg::mem_op_e [NUM_LANES-1:0]               smem_req_op,
    input  logic [NUM_LANES-1:0][SMEM_LOG_SIZE-$clog2(smem_pkg::WORD_SIZE)-1:0] smem_req_addr,
    input  logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   smem_req_byteen,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  smem_req_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   smem_req_tag,
    output logic [NUM_LANES-1:0]                            smem_req_ready,

    output logic [NUM_LANES-1:0]                            smem_rsp_valid,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  smem_rsp_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   smem_rsp_tag,
    input  logic [NUM_LANES-1:0]                            smem_rsp_ready
);
    import smem_pkg::*;

    localparam int SMEM_AW    = SMEM_LOG_SIZE - $clog2(WORD_SIZE);
    localparam int BANK_DEPTH = (2 ** SMEM_AW) / NUM_BANKS;
    localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int IDX_W      = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem [NUM_BANKS][BANK_DEPTH];

    logic [NUM_LANES-1:0][BANK_SEL_W-1:0] lane_bank;
    logic [NUM_LANES-1:0][IDX_W-1:0]      lane_idx;
    logic [NUM_LANES-1:0]                 rsp_free;
    logic [NUM_LANES-1:0]                 grant;
    logic [NUM_BANKS-1:0]                 bank_taken;

    logic [NUM_LANES-1:0]                 rsp_valid_q;
    logic [NUM_LANES-1:0][DATA_WIDTH-1:0] rsp_data_q;
    logic [NUM_LANES-1:0][TAG_WIDTH-1:0]  rsp_tag_q;

    // Low word-address bits pick the bank, the rest index into it
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_bank[i] = BANK_SEL_W'(smem_req_addr[i] % NUM_BANKS);
            lane_idx[i]  = IDX_W'(smem_req_addr[i] / NUM_BANKS);
            rsp_free[i]  = !rsp_valid_q[i] || smem_rsp_ready[i];
        end
    end

    // Fixed priority per bank: the lowest lane with a free response register wins
    always_comb begin
        bank_taken     = '0;
        smem_req_ready = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rsp_free[i] && !bank_taken[lane_bank[i]]) begin
                smem_req_ready[i] = 1'b1;
                if (smem_req_valid[i]) begin
                    bank_taken[lane_bank[i]] = 1'b1;
                end
            end
        end
        grant = smem_req_valid & smem_req_ready;
    end

    // At most one lane owns a bank per cycle, so the lanes never collide here
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (grant[i]) begin
                if (smem_req_op[i] == MEM_WRITE) begin
                    for (int b = 0; b < WORD_SIZE; b++) begin
                        if (smem_req_byteen[i][b]) begin
                            mem[lane_bank[i]][lane_idx[i]][b*8 +: 8] <=
                                smem_req_data[i][b*8 +: 8];
                        end
                    end
                end else begin
                    rsp_data_q[i] <= mem[lane_bank[i]][lane_idx[i]];
                    rsp_tag_q[i]  <= smem_req_tag[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (grant[i] && smem_req_op[i] == MEM_READ) begin
                    rsp_valid_q[i] <= 1'b1;
                end else if (smem_rsp_ready[i]) begin
                    rsp_valid_q[i] <= 1'b0;
                end
            end
        end
    end

    assign smem_rsp_valid = rsp_valid_q;
    assign smem_rsp_data  = rsp_data_q;
    assign smem_rsp_tag   = rsp_tag_q;

endmodule

// File: smem_route_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decode stage: steers each lane's request to shared memory or the data cache
// and records the route of every accepted read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module smem_route_decode #(
    parameter int NUM_LANES     = 2,
    parameter int SMEM_LOG_SIZE = 10,
    parameter int NUM_BANKS     = 2,
    parameter logic [smem_pkg::ADDR_WIDTH-1:0] SMEM_BASE = 32'h0000_4000
) (
    input  logic [NUM_LANES-1:0]                            core_req_valid,
    input  smem_pkg::mem_op_e [NUM_LANES-1:0]               core_req_op,
    input  logic [NUM_LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]  core_req_addr,
    input  logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   core_req_byteen,
    input  logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  core_req_data,
    input  logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   core_req_tag,
    output logic [NUM_LANES-1:0]                            core_req_ready,

    output logic [NUM_LANES-1:0]                            dcache_req_valid,
    output smem_pkg::mem_op_e [NUM_LANES-1:0]               dcache_req_op,
    output logic [NUM_LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]  dcache_req_addr,
    output logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   dcache_req_byteen,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  dcache_req_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   dcache_req_tag,
    input  logic [NUM_LANES-1:0]                            dcache_req_ready,

    output logic [NUM_LANES-1:0]                            smem_req_valid,
    output smem_pkg::mem_op_e [NUM_LANES-1:0]               smem_req_op,
    output logic [NUM_LANES-1:0][SMEM_LOG_SIZE-$clog2(smem_pkg::WORD_SIZE)-1:0] smem_req_addr,
    output logic [NUM_LANES-1:0][smem_pkg::WORD_SIZE-1:0]   smem_req_byteen,
    output logic [NUM_LANES-1:0][smem_pkg::DATA_WIDTH-1:0]  smem_req_data,
    output logic [NUM_LANES-1:0][smem_pkg::TAG_WIDTH-1:0]   smem_req_tag,
    input  logic [NUM_LANES-1:0]                            smem_req_ready,

    output logic [NUM_LANES-1:0]                            order_push,
    output smem_pkg::route_e [NUM_LANES-1:0]                order_route,
    input  logic [NUM_LANES-1:0]                            order_full
);
    import smem_pkg::*;

    localparam int WORD_BITS = $clog2(WORD_SIZE);
    localparam int SMEM_AW   = SMEM_LOG_SIZE - WORD_BITS;

    // The window has to hold at least one word per bank
    if (SMEM_AW < $clog2(NUM_BANKS)) begin : g_cfg_check
        $error("shared-memory window is smaller than the bank count");
    end

    logic [NUM_LANES-1:0] is_read;
    logic [NUM_LANES-1:0] order_ok;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Only the upper address bits are compared, the window is aligned to its size
            if (core_req_addr[i][ADDR_WIDTH-1:SMEM_LOG_SIZE]
                    == SMEM_BASE[ADDR_WIDTH-1:SMEM_LOG_SIZE]) begin
                order_route[i] = ROUTE_SMEM;
            end else begin
                order_route[i] = ROUTE_DCACHE;
            end
            is_read[i]  = (core_req_op[i] == MEM_READ);
            // A read needs a free slot in the lane's order queue
            order_ok[i] = !is_read[i] || !order_full[i];

            smem_req_valid[i]   = core_req_valid[i] && order_ok[i]
                                  && (order_route[i] == ROUTE_SMEM);
            dcache_req_valid[i] = core_req_valid[i] && order_ok[i]
                                  && (order_route[i] == ROUTE_DCACHE);

            core_req_ready[i] = order_ok[i] && ((order_route[i] == ROUTE_SMEM)
                                ? smem_req_ready[i] : dcache_req_ready[i]);
            order_push[i] = core_req_valid[i] && core_req_ready[i] && is_read[i];
        end
    end

    // Payload goes to both destinations, only the valid differs
    assign dcache_req_op     = core_req_op;
    assign dcache_req_addr   = core_req_addr;
    assign dcache_req_byteen = core_req_byteen;
    assign dcache_req_data   = core_req_data;
    assign dcache_req_tag    = core_req_tag;

    assign smem_req_op     = core_req_op;
    assign smem_req_byteen = core_req_byteen;
    assign smem_req_data   = core_req_data;
    assign smem_req_tag    = core_req_tag;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            smem_req_addr[i] = core_req_addr[i][SMEM_LOG_SIZE-1:WORD_BITS];
        end
    end

endmodule

// File: smem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths and enums for the shared-memory unit
// Imported by every stage and by the top level
// ~~~~~~~~~~~~~~~~~~~~
package smem_pkg;

    // Byte address width of core and data-cache requests
    parameter int ADDR_WIDTH = 32;

    // Bytes per word and the matching data width
    parameter int WORD_SIZE  = 4;
    parameter int DATA_WIDTH = WORD_SIZE * 8;

    // Tag width that the core uses to match responses
    parameter int TAG_WIDTH = 8;

    // Outstanding reads tracked per lane by the result stage
    parameter int ORDER_DEPTH = 4;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Destination of a request, also kept per read in the order queue
    typedef enum logic {
        ROUTE_DCACHE = 1'b0,
        ROUTE_SMEM   = 1'b1
    } route_e;

endpackage
